// File: dv/l2_cache_checker.sv
// ========================================
// Protocol assertions for the L2 cache,
// bound into l2_cache_top
// ========================================

`timescale 1ns/10ps

module l2_cache_checker (
	input logic                   clk,
	input logic                   rst_n,
	input l2_cache_pkg::rd_beat_t r,
	input logic                   r_valid,
	input logic                   r_ready,
	input l2_cache_pkg::addr_t    mem_araddr,
	input logic                   mem_ar_valid,
	input logic                   mem_ar_ready,
	input logic                   mem_r_ready,
	input logic                   fence_done,
	input l2_cache_pkg::ctrl_state_t state
);
	import l2_cache_pkg::*;

	// Client beat held steady while stalled
	r_hold: assert property (@(posedge clk) disable iff (!rst_n)
		r_valid && !r_ready |=> r_valid && $stable(r))
		else $error("client read beat changed before r_ready");

	// Memory burst address held until accepted
	ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
		mem_ar_valid && !mem_ar_ready |=> mem_ar_valid && $stable(mem_araddr))
		else $error("memory read address changed before mem_ar_ready");

	// Done is a single-cycle pulse
	fence_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		fence_done |=> !fence_done)
		else $error("fence_done held for more than one cycle");

	// Memory data only taken while a line fill runs
	r_ready_fill: assert property (@(posedge clk) disable iff (!rst_n)
		mem_r_ready |-> state == st_refill)
		else $error("mem_r_ready high outside a refill");

	// No client data straight out of reset
	r_quiet: assert property (@(posedge clk)
		!rst_n |=> !r_valid)
		else $error("r_valid high after reset");

endmodule

bind l2_cache_top l2_cache_checker u_checker (
	.clk(clk), .rst_n(rst_n),
	.r(r), .r_valid(r_valid), .r_ready(r_ready),
	.mem_araddr(mem_araddr), .mem_ar_valid(mem_ar_valid), .mem_ar_ready(mem_ar_ready),
	.mem_r_ready(mem_r_ready), .fence_done(fence_done),
	.state(u_ctrl.state_q)
);

// File: dv/l2_cache_tb.sv
// ========================================
// L2 cache testbench, memory model, bus
// driver, file-driven sequencer, compares
// ========================================

`timescale 1ns/10ps

module l2_cache_tb;
	import l2_cache_pkg::*;

	logic clk = 1'b0;
	logic rst_n;
	rd_req_t ar;
	logic ar_valid;
	logic ar_ready;
	rd_beat_t r;
	logic r_valid;
	logic r_ready = 1'b0;
	addr_t mem_araddr;
	logic mem_ar_valid;
	logic mem_ar_ready = 1'b0;
	rd_beat_t mem_r = '0;
	logic mem_r_valid = 1'b0;
	logic mem_r_ready;
	logic fence;
	logic fence_done;

	// Test table from the data file
	string t_name[$];
	string t_kind[$];
	string t_fetch[$];
	addr_t t_addr[$];
	int t_len[$];
	// Bursts and beats seen by the bus driver
	addr_t fetch_q[$];
	rd_beat_t got_beats[$];
	int seed = 87;
	logic stall = 1'b0;
	// Memory burst in flight
	int mem_left = 0;
	addr_t mem_addr = '0;
	logic mem_fired = 1'b0;
	int cycles = 0;
	int limit = 0;

	l2_cache_top #(.WAYS(4)) u_dut (.*);

	always #2 clk = ~clk;

	task automatic report_fail(input string what);
		$display("%s", what);
		$display("Something failed");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_beat(input string name, input rd_beat_t exp, input rd_beat_t act);
		if (act !== exp)
			report_fail($sformatf("ERR %s expected data %h last %b actual data %h last %b",
				name, exp.data, exp.last, act.data, act.last));
	endtask

	task automatic check_fetch(input string name, input addr_t exp, input addr_t act);
		if (act !== exp)
			report_fail($sformatf("ERR %s expected fetch %h actual %h", name, exp, act));
	endtask

	task automatic check_fence(input string name, input bit exp, input bit act);
		if (act !== exp)
			report_fail($sformatf("ERR %s expected fence_done %b actual %b", name, exp, act));
	endtask

	// Memory side and client R side in one process, all driven on the falling edge
	always @(negedge clk) begin
		// Beat taken on the last rising edge
		if (mem_fired)
			mem_r_valid = 1'b0;
		if (!mem_r_valid && mem_left > 0 && (!stall || ($random(seed) & 3) != 0)) begin
			mem_r_valid = 1'b1;
			// Upper half is the byte address, lower half its inverse
			mem_r.data = {mem_addr, ~mem_addr};
			mem_r.last = (mem_left == 1);
		end
		mem_fired = mem_r_valid && mem_r_ready;
		if (mem_fired) begin
			mem_left--;
			mem_addr = mem_addr + 32'd8;
		end
		mem_ar_ready = !stall || ($random(seed) & 1) != 0;
		// Burst of 16 starts after the address handshake
		if (mem_ar_valid && mem_ar_ready) begin
			fetch_q.push_back(mem_araddr);
			mem_left = 16;
			mem_addr = mem_araddr;
		end
		r_ready = !stall || ($random(seed) & 3) != 0;
		if (r_valid && r_ready)
			got_beats.push_back(r);
	end

	task automatic run_read(input string name, input addr_t addr, input int len,
		input string fetch);
		rd_beat_t exp;
		addr_t beat_addr;
		addr_t line_addr;
		if (got_beats.size() != 0)
			report_fail($sformatf("%s: beats arrived after the previous burst ended", name));
		fetch_q.delete();
		@(negedge clk);
		ar.addr = addr;
		ar.len = 8'(len);
		ar_valid = 1'b1;
		// Miss accepts only after the line fill
		while (!ar_ready)
			@(negedge clk);
		@(negedge clk);
		ar_valid = 1'b0;
		while (got_beats.size() < len + 1)
			@(posedge clk);
		// Beats walk up from the start beat, 8 bytes apart
		beat_addr = {addr[31:3], 3'b000};
		for (int i = 0; i <= len; i++) begin
			exp.data = {beat_addr, ~beat_addr};
			exp.last = (i == len);
			check_beat(name, exp, got_beats[i]);
			beat_addr = beat_addr + 32'd8;
		end
		got_beats.delete();
		line_addr = {addr[31:7], 7'b0};
		if (fetch == "yes" && fetch_q.size() != 1)
			report_fail($sformatf("%s: expected one memory burst, saw %0d", name, fetch_q.size()));
		if (fetch == "no" && fetch_q.size() != 0)
			report_fail($sformatf("%s: memory was read on what should be a hit", name));
		foreach (fetch_q[k])
			check_fetch(name, line_addr, fetch_q[k]);
	endtask

	task automatic run_fence(input string name);
		@(negedge clk);
		fence = 1'b1;
		while (!fence_done)
			@(negedge clk);
		fence = 1'b0;
		@(negedge clk);
		// Pulse must already be gone
		check_fence(name, 1'b0, fence_done);
	endtask

	always @(posedge clk) begin
		cycles++;
		if (limit != 0 && cycles > limit)
			report_fail($sformatf("timeout, no progress after %0d cycles", cycles));
	end

	initial begin
		int fd;
		int n;
		string line;
		string name;
		string kind;
		string fetch;
		addr_t addr;
		int len;
		ar = '0;
		ar_valid = 1'b0;
		fence = 1'b0;
		rst_n = 1'b0;
		fd = $fopen("dv/l2_cache_tests.txt", "r");
		if (fd == 0)
			report_fail("could not open dv/l2_cache_tests.txt");
		while (!$feof(fd)) begin
			n = $fgets(line, fd);
			n = $sscanf(line, "%s %s %h %d %s", name, kind, addr, len, fetch);
			// Comment lines start with a hash
			if (n == 5 && name.substr(0, 0) != "#") begin
				t_name.push_back(name);
				t_kind.push_back(kind);
				t_addr.push_back(addr);
				t_len.push_back(len);
				t_fetch.push_back(fetch);
			end
		end
		$fclose(fd);
		// Two passes plus the fence between them
		limit = (2 * t_name.size() + 1) * 200;
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		// Second pass repeats everything under random stalls
		for (int pass = 0; pass < 2; pass++) begin
			stall = (pass == 1);
			for (int i = 0; i < t_name.size(); i++) begin
				if (t_kind[i] == "fence")
					run_fence(t_name[i]);
				else
					run_read(t_name[i], t_addr[i], t_len[i], t_fetch[i]);
			end
			if (pass == 0)
				run_fence("pass_fence");
		end
		$display("Everything OK");
		$finish;
	end

endmodule

// File: dv/l2_cache_tests.txt
# name kind(read/fence) addr(hex) len(beats-1) fetch
# fetch is yes, no, or any when the evicted way is picked by the LFSR
cold_read read 00001000 3 yes
same_line_hit read 00001040 7 no
same_line_one read 00001008 0 no
cold_full_line read 00002080 15 yes
hit_line_tail read 000020f0 1 no
fence_all fence 00000000 0 no
refetch_line0 read 00001000 1 yes
refetch_line1 read 000020f8 0 yes
set4_way0 read 00010200 2 yes
set4_way1 read 00020200 5 yes
set4_way2 read 00030210 4 yes
set4_way3 read 00040200 0 yes
set4_evict read 00050200 15 yes
reread_way0 read 00010200 2 any
reread_way1 read 00020200 5 any
reread_way2 read 00030210 4 any
reread_way3 read 00040200 0 any
len_start1 read 00003008 0 yes
len_start1_long read 00003008 14 no
len_start5 read 00003028 4 no
len_start9 read 00003048 6 no
len_start15 read 00003078 0 no
len_start3 read 00004018 12 yes
len_full_line read 00004000 15 no

// File: flist.f
logic/l2_cache_pkg.sv
logic/l2_data_array.sv
logic/l2_tag_array.sv
logic/l2_refill.sv
logic/l2_read_port.sv
logic/l2_cache_ctrl.sv
logic/l2_cache_top.sv
dv/l2_cache_checker.sv
dv/l2_cache_tb.sv

// File: logic/l2_cache_ctrl.sv
// =====================================
// Cache controller FSM, request lock,
// hit/miss decision and fence handling
// =====================================

`timescale 1ns/10ps

module l2_cache_ctrl #(
	parameter int WAYS = 4
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  l2_cache_pkg::rd_req_t ar,
	input  logic                  ar_valid,
	input  logic                  fence,
	input  logic [WAYS-1:0]       hit_way,
	input  logic                  fill_done,
	input  logic                  resp_done,
	output logic                  ar_ready,
	output logic                  fence_done,
	output l2_cache_pkg::addr_t   lookup_addr,
	output logic                  alloc,
	output logic                  flush,
	output logic                  fill_start,
	output l2_cache_pkg::addr_t   fill_addr,
	output logic                  resp_start,
	output logic [WAYS-1:0]       resp_way,
	output l2_cache_pkg::rd_req_t resp_req
);
	import l2_cache_pkg::*;

	ctrl_state_t state_q;
	ctrl_state_t state_d;
	rd_req_t req_q;
	logic in_check;
	logic hit;

	assign in_check = (state_q == st_check);
	assign hit = |hit_way;

	// Tags are always looked up with the locked request
	assign lookup_addr = req_q.addr;

	// Hit in check accepts the request and starts streaming
	assign ar_ready = in_check && hit;
	assign resp_start = in_check && hit;
	assign resp_way = hit_way;
	assign resp_req = req_q;

	// Miss claims a victim and fetches the whole line
	assign alloc = in_check && !hit;
	assign fill_start = in_check && !hit;
	assign fill_addr = line_base(req_q.addr);

	// One cycle in fence clears every valid bit
	assign flush = (state_q == st_fence);
	assign fence_done = (state_q == st_fence);

	always_comb begin
		state_d = state_q;
		case (state_q)
			st_idle: begin
				// Fence wins over a pending read
				if (fence)
					state_d = st_fence;
				else if (ar_valid)
					state_d = st_check;
			end
			st_check:
				state_d = hit ? st_resp : st_refill;
			st_refill:
				// Recheck once the last beat is written
				if (fill_done)
					state_d = st_check;
			st_resp:
				if (resp_done)
					state_d = st_idle;
			st_fence:
				state_d = st_idle;
			default:
				state_d = st_idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			state_q <= st_idle;
		else
			state_q <= state_d;
	end

	// Request held from leaving idle until the response ends
	always_ff @(posedge clk) begin
		if (state_q == st_idle && state_d == st_check)
			req_q <= ar;
	end

endmodule

// File: logic/l2_cache_pkg.sv
// =====================================
// Cache geometry, address fields,
// controller states and channel structs
// =====================================

package l2_cache_pkg;

	// Address and beat widths
	localparam int ADDR_W = 32;
	localparam int BEAT_W = 64;
	// 16 beats of 8 bytes make a 128-byte line
	localparam int LINE_BEATS = 16;
	localparam int OFFSET_W = $clog2(LINE_BEATS * BEAT_W / 8);
	localparam int SETS = 32;
	localparam int SET_W = $clog2(SETS);
	// Tag is whatever sits above set and offset
	localparam int TAG_W = ADDR_W - SET_W - OFFSET_W;

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [BEAT_W-1:0] beat_t;
	typedef logic [$clog2(LINE_BEATS)-1:0] beat_idx_t;
	typedef logic [SET_W-1:0] set_idx_t;
	typedef logic [TAG_W-1:0] tag_t;

	// Read-address payload, len is beats minus one
	typedef struct packed {
		addr_t      addr;
		logic [7:0] len;
	} rd_req_t;

	// Read-data beat, shared by client and memory side
	typedef struct packed {
		beat_t data;
		logic  last;
	} rd_beat_t;

	typedef enum logic [2:0] {
		st_idle,
		st_check,
		st_refill,
		st_resp,
		st_fence
	} ctrl_state_t;

	// Address field helpers
	function automatic tag_t addr_tag(input addr_t a);
		return a[ADDR_W-1 -: TAG_W];
	endfunction

	function automatic set_idx_t addr_set(input addr_t a);
		return a[OFFSET_W +: SET_W];
	endfunction

	function automatic beat_idx_t addr_beat(input addr_t a);
		return a[OFFSET_W-1 -: $bits(beat_idx_t)];
	endfunction

	// First byte of the line holding a
	function automatic addr_t line_base(input addr_t a);
		return {a[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
	endfunction

endpackage

// File: logic/l2_cache_top.sv
// =====================================
// L2 cache top level, wires controller,
// tag and data arrays, refill, read port
// =====================================

`timescale 1ns/10ps

module l2_cache_top #(
	parameter int WAYS = 4
) (
	input  logic                   clk,
	input  logic                   rst_n,
	// Client read-address channel
	input  l2_cache_pkg::rd_req_t  ar,
	input  logic                   ar_valid,
	output logic                   ar_ready,
	// Client read-data channel
	output l2_cache_pkg::rd_beat_t r,
	output logic                   r_valid,
	input  logic                   r_ready,
	// Memory read-address channel, always 16-beat incrementing bursts
	output l2_cache_pkg::addr_t    mem_araddr,
	output logic                   mem_ar_valid,
	input  logic                   mem_ar_ready,
	// Memory read-data channel
	input  l2_cache_pkg::rd_beat_t mem_r,
	input  logic                   mem_r_valid,
	output logic                   mem_r_ready,
	// Level fence request and done pulse
	input  logic                   fence,
	output logic                   fence_done
);
	import l2_cache_pkg::*;

	// Controller to tag array
	addr_t lookup_addr;
	logic alloc;
	logic flush;
	logic [WAYS-1:0] hit_way;
	logic [WAYS-1:0] victim_way;
	// Controller to refill engine
	logic fill_start;
	addr_t fill_addr;
	logic fill_done;
	// Controller to read port
	logic resp_start;
	logic [WAYS-1:0] resp_way;
	rd_req_t resp_req;
	logic resp_done;
	// Data array write side, fed by refill
	logic wr_en;
	logic [WAYS-1:0] wr_way;
	set_idx_t wr_set;
	beat_idx_t wr_beat;
	beat_t wr_data;
	// Data array read side, driven by read port
	logic [WAYS-1:0] rd_way;
	set_idx_t rd_set;
	beat_idx_t rd_beat;
	beat_t rd_data;

	l2_cache_ctrl #(.WAYS(WAYS)) u_ctrl (
		.clk(clk), .rst_n(rst_n),
		.ar(ar), .ar_valid(ar_valid), .fence(fence),
		.hit_way(hit_way), .fill_done(fill_done), .resp_done(resp_done),
		.ar_ready(ar_ready), .fence_done(fence_done),
		.lookup_addr(lookup_addr), .alloc(alloc), .flush(flush),
		.fill_start(fill_start), .fill_addr(fill_addr),
		.resp_start(resp_start), .resp_way(resp_way), .resp_req(resp_req)
	);

	l2_tag_array #(.WAYS(WAYS)) u_tags (
		.clk(clk), .rst_n(rst_n),
		.lookup_addr(lookup_addr), .alloc(alloc), .flush(flush),
		.hit_way(hit_way), .victim_way(victim_way)
	);

	l2_data_array #(.WAYS(WAYS)) u_data (
		.clk(clk),
		.wr_en(wr_en), .wr_way(wr_way), .wr_set(wr_set),
		.wr_beat(wr_beat), .wr_data(wr_data),
		.rd_way(rd_way), .rd_set(rd_set), .rd_beat(rd_beat), .rd_data(rd_data)
	);

	l2_refill #(.WAYS(WAYS)) u_refill (
		.clk(clk), .rst_n(rst_n),
		.fill_start(fill_start), .fill_addr(fill_addr), .victim_way(victim_way),
		.mem_ar_ready(mem_ar_ready), .mem_r(mem_r), .mem_r_valid(mem_r_valid),
		.mem_araddr(mem_araddr), .mem_ar_valid(mem_ar_valid),
		.mem_r_ready(mem_r_ready), .fill_done(fill_done),
		.wr_en(wr_en), .wr_way(wr_way), .wr_set(wr_set),
		.wr_beat(wr_beat), .wr_data(wr_data)
	);

	l2_read_port #(.WAYS(WAYS)) u_rd (
		.clk(clk), .rst_n(rst_n),
		.resp_start(resp_start), .resp_way(resp_way), .resp_req(resp_req),
		.r_ready(r_ready), .rd_data(rd_data),
		.r(r), .r_valid(r_valid), .resp_done(resp_done),
		.rd_way(rd_way), .rd_set(rd_set), .rd_beat(rd_beat)
	);

endmodule

// File: logic/l2_data_array.sv
// =====================================
// Line storage, one write port and one
// registered read port
// =====================================

`timescale 1ns/10ps

module l2_data_array #(
	parameter int WAYS = 4
) (
	input  logic                    clk,
	input  logic                    wr_en,
	input  logic [WAYS-1:0]         wr_way,
	input  l2_cache_pkg::set_idx_t  wr_set,
	input  l2_cache_pkg::beat_idx_t wr_beat,
	input  l2_cache_pkg::beat_t     wr_data,
	input  logic [WAYS-1:0]         rd_way,
	input  l2_cache_pkg::set_idx_t  rd_set,
	input  l2_cache_pkg::beat_idx_t rd_beat,
	output l2_cache_pkg::beat_t     rd_data
);
	import l2_cache_pkg::*;

	localparam int WAY_W = $clog2(WAYS);

	beat_t mem [SETS][WAYS][LINE_BEATS];

	// One-hot way to array index
	function automatic logic [WAY_W-1:0] way_index(input logic [WAYS-1:0] oh);
		logic [WAY_W-1:0] idx;
		idx = '0;
		for (int i = 0; i < WAYS; i++)
			if (oh[i])
				idx = idx | WAY_W'(i);
		return idx;
	endfunction

	// Read data lands one cycle after the address
	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_set][way_index(wr_way)][wr_beat] <= wr_data;
		rd_data <= mem[rd_set][way_index(rd_way)][rd_beat];
	end

endmodule

// File: logic/l2_read_port.sv
// =====================================
// Client R channel, beat stepping,
// stall holding register and rlast
// =====================================

`timescale 1ns/10ps

module l2_read_port #(
	parameter int WAYS = 4
) (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    resp_start,
	input  logic [WAYS-1:0]         resp_way,
	input  l2_cache_pkg::rd_req_t   resp_req,
	input  logic                    r_ready,
	input  l2_cache_pkg::beat_t     rd_data,
	output l2_cache_pkg::rd_beat_t  r,
	output logic                    r_valid,
	output logic                    resp_done,
	output logic [WAYS-1:0]         rd_way,
	output l2_cache_pkg::set_idx_t  rd_set,
	output l2_cache_pkg::beat_idx_t rd_beat
);
	import l2_cache_pkg::*;

	logic [WAYS-1:0] way_q;
	set_idx_t set_q;
	beat_idx_t beat_q;
	// Reads left to issue after the current one
	logic [7:0] left_q;
	logic issue_q;
	// Array data arriving this cycle
	logic pend_q;
	logic pend_last_q;
	// Beat parked while the client stalls
	logic hold_q;
	logic hold_last_q;
	beat_t hold_data_q;
	logic out_free;
	logic rd_fire;

	assign rd_way = way_q;
	assign rd_set = set_q;
	assign rd_beat = beat_q;

	assign r_valid = pend_q || hold_q;
	assign r.data = hold_q ? hold_data_q : rd_data;
	assign r.last = hold_q ? hold_last_q : pend_last_q;
	assign resp_done = r_valid && r_ready && r.last;

	// Prefetch only when the output slot frees up this cycle
	assign out_free = !r_valid || r_ready;
	assign rd_fire = issue_q && out_free;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			issue_q <= 1'b0;
			pend_q <= 1'b0;
			pend_last_q <= 1'b0;
			hold_q <= 1'b0;
		end else begin
			pend_q <= rd_fire;
			pend_last_q <= rd_fire && (left_q == '0);
			if (resp_start)
				issue_q <= 1'b1;
			else if (rd_fire && left_q == '0)
				issue_q <= 1'b0;
			hold_q <= r_valid && !r_ready;
		end
	end

	always_ff @(posedge clk) begin
		if (resp_start) begin
			way_q <= resp_way;
			set_q <= addr_set(resp_req.addr);
			beat_q <= addr_beat(resp_req.addr);
			left_q <= resp_req.len;
		end else if (rd_fire) begin
			beat_q <= beat_q + 1'b1;
			left_q <= left_q - 1'b1;
		end
		// Keep the presented beat stable under back-pressure
		if (r_valid && !r_ready) begin
			hold_data_q <= r.data;
			hold_last_q <= r.last;
		end
	end

endmodule

// File: logic/l2_refill.sv
// =====================================
// Line fill engine, memory AR and R
// channels and the fill beat counter
// =====================================

`timescale 1ns/10ps

module l2_refill #(
	parameter int WAYS = 4
) (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    fill_start,
	input  l2_cache_pkg::addr_t     fill_addr,
	input  logic [WAYS-1:0]         victim_way,
	input  logic                    mem_ar_ready,
	input  l2_cache_pkg::rd_beat_t  mem_r,
	input  logic                    mem_r_valid,
	output l2_cache_pkg::addr_t     mem_araddr,
	output logic                    mem_ar_valid,
	output logic                    mem_r_ready,
	output logic                    fill_done,
	output logic                    wr_en,
	output logic [WAYS-1:0]         wr_way,
	output l2_cache_pkg::set_idx_t  wr_set,
	output l2_cache_pkg::beat_idx_t wr_beat,
	output l2_cache_pkg::beat_t     wr_data
);
	import l2_cache_pkg::*;

	// Line-aligned burst address
	addr_t line_q;
	// Next beat slot within the line
	beat_idx_t beat_q;

	assign mem_araddr = line_q;

	// Every accepted memory beat goes straight into the victim way
	assign wr_en = mem_r_valid && mem_r_ready;
	assign wr_way = victim_way;
	assign wr_set = addr_set(line_q);
	assign wr_beat = beat_q;
	assign wr_data = mem_r.data;
	assign fill_done = wr_en && mem_r.last;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			mem_ar_valid <= 1'b0;
			mem_r_ready <= 1'b0;
			beat_q <= '0;
		end else if (fill_start) begin
			mem_ar_valid <= 1'b1;
			mem_r_ready <= 1'b1;
			beat_q <= '0;
		end else begin
			if (mem_ar_valid && mem_ar_ready)
				mem_ar_valid <= 1'b0;
			if (wr_en)
				beat_q <= beat_q + 1'b1;
			// Burst ends on the beat flagged last
			if (fill_done)
				mem_r_ready <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (fill_start)
			line_q <= fill_addr;
	end

endmodule

// File: logic/l2_tag_array.sv
// =====================================
// Tags and valid bits per set and way,
// parallel hit compare, victim choice
// =====================================

`timescale 1ns/10ps

module l2_tag_array #(
	parameter int WAYS = 4
) (
	input  logic                clk,
	input  logic                rst_n,
	input  l2_cache_pkg::addr_t lookup_addr,
	input  logic                alloc,
	input  logic                flush,
	output logic [WAYS-1:0]     hit_way,
	output logic [WAYS-1:0]     victim_way
);
	import l2_cache_pkg::*;

	localparam int WAY_W = $clog2(WAYS);

	tag_t tags_q [SETS][WAYS];
	logic [SETS-1:0][WAYS-1:0] valid_q;
	// Free-running replacement source
	logic [15:0] lfsr_q;
	set_idx_t set;
	tag_t tag;
	logic [WAYS-1:0] set_valid;
	logic [WAYS-1:0] victim_d;

	assign set = addr_set(lookup_addr);
	assign tag = addr_tag(lookup_addr);
	assign set_valid = valid_q[set];

	// All ways compared at once, zero on a miss
	always_comb begin
		for (int w = 0; w < WAYS; w++)
			hit_way[w] = set_valid[w] && (tags_q[set][w] == tag);
	end

	// Full set falls back to the LFSR pick
	// Scan from the top so the lowest invalid way wins
	always_comb begin
		victim_d = WAYS'(1) << lfsr_q[WAY_W-1:0];
		for (int w = WAYS - 1; w >= 0; w--)
			if (!set_valid[w])
				victim_d = WAYS'(1) << w;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			valid_q <= '0;
			lfsr_q <= 16'hace1;
		end else begin
			// Taps 16, 14, 13, 11
			lfsr_q <= {lfsr_q[14:0], lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10]};
			if (flush)
				valid_q <= '0;
			else if (alloc)
				valid_q[set] <= set_valid | victim_d;
		end
	end

	// Victim way stays put for the whole line fill
	always_ff @(posedge clk) begin
		if (alloc) begin
			victim_way <= victim_d;
			for (int w = 0; w < WAYS; w++)
				if (victim_d[w])
					tags_q[set][w] <= tag;
		end
	end

endmodule

// File: run_sim.sh
#!/bin/sh
# Build the L2 cache testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --assert \
	--top-module l2_cache_tb \
	-f flist.f \
	--Mdir obj_dir \
	-o l2_cache_sim

./obj_dir/l2_cache_sim 2>&1 | tee sim.log

if grep -q "Everything OK" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed, see sim.log"
	exit 1
fi
